// ==== Makefile ====
# Verilator build and run of the Z buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_zbuf_top
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= >>> PASS

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard design/*.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
+incdir+design
design/zbuf_pkg.sv
design/zbuf_scm.sv
design/zbuf_load_stage.sv
design/zbuf_buffer.sv
design/zbuf_store_stage.sv
design/zbuf_top.sv
verif/zbuf_chk.sv
verif/tb_zbuf_top.sv

// ==== design/zbuf_buffer.sv ====
// ******************************
// Z buffer FSM and counters
// Bias load and push, result fill and store
// ******************************

`timescale 1ns/1ps
`include "zbuf_macros.svh"

module zbuf_buffer
  import zbuf_pkg::*;
(
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       clear_i,
  input  tile_cfg_t                                  cfg_i,
  input  z_buffer_ctrl_t                             ctrl_i,
  input  logic [`ZBUF_ARRAY_W-1:0][`ZBUF_WORD_W-1:0] z_row_i,
  input  logic [`ZBUF_MEM_DW-1:0]                    y_col_i,
  output logic [`ZBUF_ARRAY_W-1:0][`ZBUF_WORD_W-1:0] y_row_o,
  output store_beat_t                                store_o,
  output z_buffer_flgs_t                             flags_o
);

  localparam int unsigned ROW_AW = $clog2(`ZBUF_BUF_D);
  localparam int unsigned COL_AW = $clog2(`ZBUF_ARRAY_W);
  localparam int unsigned BYTES  = `ZBUF_WORD_W / 8;

  zbuf_state_e state_q, state_d;

  logic [ROW_AW-1:0] fill_row_q, push_row_q;
  logic [COL_AW-1:0] load_col_q, store_col_q;
  logic [ROW_AW-1:0] fill_last, push_last;
  logic [COL_AW-1:0] load_last, store_last;

  logic load_en, store_en;
  logic y_ready, z_valid;
  logic fill_hit, load_hit, push_hit, store_hit;

  logic [`ZBUF_MEM_DW-1:0]   col_rdata;
  logic [`ZBUF_MEM_DW/8-1:0] z_strb;

  zbuf_scm i_scm (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .row_we_i    ( ctrl_i.fill ),
    .col_we_i    ( y_ready     ),
    .row_waddr_i ( fill_row_q  ),
    .col_waddr_i ( load_col_q  ),
    .row_wdata_i ( z_row_i     ),
    .col_wdata_i ( y_col_i     ),
    .row_raddr_i ( push_row_q  ),
    .col_raddr_i ( store_col_q ),
    .row_rdata_o ( y_row_o     ),
    .col_rdata_o ( col_rdata   )
  );

  assign fill_last  = ROW_AW'(cfg_i.z_height - 4'd1);
  assign push_last  = ROW_AW'(cfg_i.y_height - 4'd1);
  assign load_last  = COL_AW'(cfg_i.y_width - 3'd1);
  assign store_last = COL_AW'(cfg_i.z_width - 3'd1);

  // A small tile may be stored before its biases are fully pushed,
  // so loading also waits for idle push and fill counters
  assign load_en  = state_q == EMPTY && !ctrl_i.fill && push_row_q == '0 && fill_row_q == '0;
  assign store_en = state_q == PUSHED;
  assign y_ready  = load_en & ctrl_i.y_valid;
  assign z_valid  = store_en & ctrl_i.ready;

  assign fill_hit  = ctrl_i.fill && fill_row_q == fill_last;
  assign load_hit  = y_ready && load_col_q == load_last;
  assign push_hit  = ctrl_i.y_push_enable && push_row_q == push_last;
  assign store_hit = z_valid && store_col_q == store_last;

  always_comb begin
    state_d = state_q;
    case (state_q)
      EMPTY: begin
        if (load_hit) state_d = LOADED;
        // Height-one tile goes straight to the store
        if (fill_hit) state_d = PUSHED;
      end
      LOADED: begin
        if (push_hit && !ctrl_i.fill) state_d = EMPTY;
        if (fill_hit) state_d = PUSHED;
      end
      PUSHED: begin
        if (store_hit) state_d = EMPTY;
      end
      default: state_d = EMPTY;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= EMPTY;
      fill_row_q  <= '0;
      load_col_q  <= '0;
      push_row_q  <= '0;
      store_col_q <= '0;
    end else if (clear_i) begin
      state_q     <= EMPTY;
      fill_row_q  <= '0;
      load_col_q  <= '0;
      push_row_q  <= '0;
      store_col_q <= '0;
    end else begin
      state_q <= state_d;
      if (ctrl_i.fill) fill_row_q <= fill_hit ? '0 : fill_row_q + 1'b1;
      if (y_ready) load_col_q <= load_hit ? '0 : load_col_q + 1'b1;
      if (ctrl_i.y_push_enable) push_row_q <= push_hit ? '0 : push_row_q + 1'b1;
      if (z_valid) store_col_q <= store_hit ? '0 : store_col_q + 1'b1;
    end
  end

  // Strobe covers the valid words of the column
  always_comb begin
    z_strb = '0;
    for (int d = 0; d < `ZBUF_BUF_D; d++) begin
      if (d < int'(cfg_i.z_height)) z_strb[d*BYTES +: BYTES] = '1;
    end
  end

  assign store_o = '{data: col_rdata, strb: z_strb};

  always_comb begin
    flags_o.y_ready  = y_ready;
    flags_o.z_valid  = z_valid;
    flags_o.loaded   = (state_q == EMPTY && load_hit) || state_q == LOADED;
    flags_o.y_pushed = push_hit;
    flags_o.empty    = store_hit ||
                       (state_q == LOADED && push_hit && cfg_i.first_load);
  end

endmodule : zbuf_buffer

// ==== design/zbuf_load_stage.sv ====
// ******************************
// Z buffer load stage
// One-beat staging of memory reads
// ******************************

`timescale 1ns/1ps
`include "zbuf_macros.svh"

module zbuf_load_stage (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    mem_rvalid_i,
  input  logic [`ZBUF_MEM_DW-1:0] mem_rdata_i,
  output logic                    mem_rready_o,
  input  logic                    y_ready_i,
  output logic                    y_valid_o,
  output logic [`ZBUF_MEM_DW-1:0] y_data_o
);

  logic                    full_q;
  logic [`ZBUF_MEM_DW-1:0] data_q;
  logic                    take;

  // Accept when empty or when the held beat leaves this cycle
  assign mem_rready_o = ~full_q | (full_q & y_ready_i);
  assign take         = mem_rvalid_i & mem_rready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (clear_i) begin
      full_q <= 1'b0;
    end else if (take) begin
      full_q <= 1'b1;
    end else if (y_ready_i) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      data_q <= mem_rdata_i;
    end
  end

  assign y_valid_o = full_q;
  assign y_data_o  = data_q;

endmodule : zbuf_load_stage

// ==== design/zbuf_macros.svh ====
// ******************************
// Z buffer sizes
// Word, array, beat and address widths
// ******************************

`ifndef ZBUF_MACROS_SVH
`define ZBUF_MACROS_SVH

// Bits per element
`define ZBUF_WORD_W 16
// Words per array row, also the storage column count
`define ZBUF_ARRAY_W 4
// Words per memory beat, also the storage row count
`define ZBUF_BUF_D 8
`define ZBUF_MEM_DW 128
`define ZBUF_ADDR_W 32

`endif

// ==== design/zbuf_pkg.sv ====
// ******************************
// Z buffer types
// FSM state, control, flags, tile shape
// ******************************

`include "zbuf_macros.svh"

package zbuf_pkg;

  typedef enum logic [1:0] {
    EMPTY,
    LOADED,
    PUSHED
  } zbuf_state_e;

  typedef struct packed {
    logic [2:0]              y_width;
    logic [3:0]              y_height;
    logic [2:0]              z_width;
    logic [3:0]              z_height;
    logic                    first_load;
    logic [`ZBUF_ADDR_W-1:0] z_base;
    logic [`ZBUF_ADDR_W-1:0] z_stride;
  } tile_cfg_t;

  typedef struct packed {
    logic fill;
    logic y_valid;
    logic y_push_enable;
    logic ready;
  } z_buffer_ctrl_t;

  typedef struct packed {
    logic y_ready;
    logic z_valid;
    logic loaded;
    logic empty;
    logic y_pushed;
  } z_buffer_flgs_t;

  // One store column with its byte strobe
  typedef struct packed {
    logic [`ZBUF_MEM_DW-1:0]   data;
    logic [`ZBUF_MEM_DW/8-1:0] strb;
  } store_beat_t;

endpackage : zbuf_pkg

// ==== design/zbuf_scm.sv ====
// ******************************
// Z buffer register array
// Row and column addressable storage
// ******************************

`timescale 1ns/1ps
`include "zbuf_macros.svh"

module zbuf_scm (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         row_we_i,
  input  logic                                         col_we_i,
  input  logic [$clog2(`ZBUF_BUF_D)-1:0]               row_waddr_i,
  input  logic [$clog2(`ZBUF_ARRAY_W)-1:0]             col_waddr_i,
  input  logic [`ZBUF_ARRAY_W-1:0][`ZBUF_WORD_W-1:0]   row_wdata_i,
  input  logic [`ZBUF_MEM_DW-1:0]                      col_wdata_i,
  input  logic [$clog2(`ZBUF_BUF_D)-1:0]               row_raddr_i,
  input  logic [$clog2(`ZBUF_ARRAY_W)-1:0]             col_raddr_i,
  output logic [`ZBUF_ARRAY_W-1:0][`ZBUF_WORD_W-1:0]   row_rdata_o,
  output logic [`ZBUF_MEM_DW-1:0]                      col_rdata_o
);

  localparam int unsigned ROW_AW = $clog2(`ZBUF_BUF_D);
  localparam int unsigned COL_AW = $clog2(`ZBUF_ARRAY_W);

  logic [`ZBUF_BUF_D-1:0][`ZBUF_ARRAY_W-1:0][`ZBUF_WORD_W-1:0] mem_q;

  // Row writes come from the array, column writes from memory beats
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '0;
    end else begin
      for (int d = 0; d < `ZBUF_BUF_D; d++) begin
        for (int w = 0; w < `ZBUF_ARRAY_W; w++) begin
          if (row_we_i && row_waddr_i == ROW_AW'(d)) begin
            mem_q[d][w] <= row_wdata_i[w];
          end else if (col_we_i && col_waddr_i == COL_AW'(w)) begin
            mem_q[d][w] <= col_wdata_i[d*`ZBUF_WORD_W +: `ZBUF_WORD_W];
          end
        end
      end
    end
  end

  assign row_rdata_o = mem_q[row_raddr_i];

  // Column read gathers one word from every row
  always_comb begin
    for (int d = 0; d < `ZBUF_BUF_D; d++) begin
      col_rdata_o[d*`ZBUF_WORD_W +: `ZBUF_WORD_W] = mem_q[d][col_raddr_i];
    end
  end

endmodule : zbuf_scm

// ==== design/zbuf_store_stage.sv ====
// ******************************
// Z buffer store stage
// Output register and write address
// ******************************

`timescale 1ns/1ps
`include "zbuf_macros.svh"

module zbuf_store_stage
  import zbuf_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      clear_i,
  input  tile_cfg_t                 cfg_i,
  input  logic                      z_valid_i,
  input  store_beat_t               beat_i,
  output logic                      ready_o,
  output logic                      mem_wvalid_o,
  output logic [`ZBUF_ADDR_W-1:0]   mem_waddr_o,
  output logic [`ZBUF_MEM_DW-1:0]   mem_wdata_o,
  output logic [`ZBUF_MEM_DW/8-1:0] mem_wstrb_o,
  input  logic                      mem_wready_i
);

  localparam int unsigned COL_AW = $clog2(`ZBUF_ARRAY_W);

  logic                      wvalid_q;
  logic [COL_AW-1:0]         col_q, col_last;
  logic [`ZBUF_ADDR_W-1:0]   offset_q, waddr_q;
  logic [`ZBUF_MEM_DW-1:0]   wdata_q;
  logic [`ZBUF_MEM_DW/8-1:0] wstrb_q;
  logic                      accept;

  assign ready_o  = ~wvalid_q | mem_wready_i;
  assign accept   = z_valid_i & ready_o;
  assign col_last = COL_AW'(cfg_i.z_width - 3'd1);

  // Offset accumulates index times stride
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wvalid_q <= 1'b0;
      col_q    <= '0;
      offset_q <= '0;
    end else if (clear_i) begin
      wvalid_q <= 1'b0;
      col_q    <= '0;
      offset_q <= '0;
    end else if (accept) begin
      wvalid_q <= 1'b1;
      col_q    <= (col_q == col_last) ? '0 : col_q + 1'b1;
      offset_q <= (col_q == col_last) ? '0 : offset_q + cfg_i.z_stride;
    end else if (mem_wready_i) begin
      wvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      waddr_q <= cfg_i.z_base + offset_q;
      wdata_q <= beat_i.data;
      wstrb_q <= beat_i.strb;
    end
  end

  assign mem_wvalid_o = wvalid_q;
  assign mem_waddr_o  = waddr_q;
  assign mem_wdata_o  = wdata_q;
  assign mem_wstrb_o  = wstrb_q;

endmodule : zbuf_store_stage

// ==== design/zbuf_top.sv ====
// ******************************
// Z buffer top level
// Load stage, buffer, store stage
// ******************************

`timescale 1ns/1ps
`include "zbuf_macros.svh"

module zbuf_top
  import zbuf_pkg::*;
(
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       clear_i,
  input  tile_cfg_t                                  cfg_i,
  input  logic                                       fill_i,
  input  logic [`ZBUF_ARRAY_W-1:0][`ZBUF_WORD_W-1:0] z_row_i,
  input  logic                                       y_push_i,
  output logic [`ZBUF_ARRAY_W-1:0][`ZBUF_WORD_W-1:0] y_row_o,
  input  logic                                       mem_rvalid_i,
  input  logic [`ZBUF_MEM_DW-1:0]                    mem_rdata_i,
  output logic                                       mem_rready_o,
  output logic                                       mem_wvalid_o,
  output logic [`ZBUF_ADDR_W-1:0]                    mem_waddr_o,
  output logic [`ZBUF_MEM_DW-1:0]                    mem_wdata_o,
  output logic [`ZBUF_MEM_DW/8-1:0]                  mem_wstrb_o,
  input  logic                                       mem_wready_i,
  output logic                                       loaded_o,
  output logic                                       y_pushed_o,
  output logic                                       empty_o
);

  logic                    y_valid, store_ready;
  logic [`ZBUF_MEM_DW-1:0] y_data;
  z_buffer_ctrl_t          ctrl;
  z_buffer_flgs_t          flags;
  store_beat_t             store_beat;

  assign ctrl = '{fill: fill_i, y_valid: y_valid, y_push_enable: y_push_i, ready: store_ready};

  zbuf_load_stage i_load (
    .clk_i        ( clk_i         ),
    .rst_ni       ( rst_ni        ),
    .clear_i      ( clear_i       ),
    .mem_rvalid_i ( mem_rvalid_i  ),
    .mem_rdata_i  ( mem_rdata_i   ),
    .mem_rready_o ( mem_rready_o  ),
    .y_ready_i    ( flags.y_ready ),
    .y_valid_o    ( y_valid       ),
    .y_data_o     ( y_data        )
  );

  zbuf_buffer i_buffer (
    .clk_i   ( clk_i      ),
    .rst_ni  ( rst_ni     ),
    .clear_i ( clear_i    ),
    .cfg_i   ( cfg_i      ),
    .ctrl_i  ( ctrl       ),
    .z_row_i ( z_row_i    ),
    .y_col_i ( y_data     ),
    .y_row_o ( y_row_o    ),
    .store_o ( store_beat ),
    .flags_o ( flags      )
  );

  zbuf_store_stage i_store (
    .clk_i        ( clk_i         ),
    .rst_ni       ( rst_ni        ),
    .clear_i      ( clear_i       ),
    .cfg_i        ( cfg_i         ),
    .z_valid_i    ( flags.z_valid ),
    .beat_i       ( store_beat    ),
    .ready_o      ( store_ready   ),
    .mem_wvalid_o ( mem_wvalid_o  ),
    .mem_waddr_o  ( mem_waddr_o   ),
    .mem_wdata_o  ( mem_wdata_o   ),
    .mem_wstrb_o  ( mem_wstrb_o   ),
    .mem_wready_i ( mem_wready_i  )
  );

  assign loaded_o   = flags.loaded;
  assign y_pushed_o = flags.y_pushed;
  assign empty_o    = flags.empty;

endmodule : zbuf_top

// ==== verif/tb_zbuf_top.sv ====
// ******************************
// Z buffer testbench
// Directed load, push, fill and store tests
// ******************************

`timescale 1ns/1ps
`include "zbuf_macros.svh"

module tb_zbuf_top
  import zbuf_pkg::*;
();

  localparam int W  = `ZBUF_WORD_W;
  localparam int AW = `ZBUF_ARRAY_W;
  localparam int BD = `ZBUF_BUF_D;
  localparam int DW = `ZBUF_MEM_DW;
  // Rough cycles per test: load/push, fill/store, stall, height one, clear
  localparam int TEST_CYCLES = 20 + 20 + 25 + 12 + 22;
  localparam int MAX_CYCLES  = 2 * TEST_CYCLES + 10;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    clear_i;
  tile_cfg_t               cfg_i;
  logic                    fill_i;
  logic [AW-1:0][W-1:0]    z_row_i;
  logic                    y_push_i;
  logic [AW-1:0][W-1:0]    y_row_o;
  logic                    mem_rvalid_i;
  logic [DW-1:0]           mem_rdata_i;
  logic                    mem_rready_o;
  logic                    mem_wvalid_o;
  logic [`ZBUF_ADDR_W-1:0] mem_waddr_o;
  logic [DW-1:0]           mem_wdata_o;
  logic [DW/8-1:0]         mem_wstrb_o;
  logic                    mem_wready_i;
  logic                    loaded_o;
  logic                    y_pushed_o;
  logic                    empty_o;

  int          errors;
  int          checks;
  int          writes;
  int          cycles;
  logic [31:0] lcg_state;
  logic [DW-1:0] sent_beat [AW];

  // Expected store columns in order
  store_beat_t exp_beat_q [$];
  logic [31:0] exp_addr_q [$];
  store_beat_t exp_beat;
  logic [31:0] exp_addr;
  logic [DW-1:0] data_mask;
  logic        stalled;
  store_beat_t held_beat;
  logic [31:0] held_addr;

  zbuf_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [W-1:0] next_word();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  // Lanes 0 to lanes-1 set, each lane_w bits wide
  function automatic logic [DW-1:0] lane_mask(input int lanes, input int lane_w);
    logic [DW-1:0] m;
    m = '0;
    for (int i = 0; i < lanes * lane_w; i++) begin
      m[i] = 1'b1;
    end
    return m;
  endfunction

  task automatic check_value(input logic [DW-1:0] got, input logic [DW-1:0] exp,
                             input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic set_cfg(input int yw, input int yh, input int zw, input int zh,
                         input logic [31:0] base, input logic [31:0] stride);
    @(posedge clk_i);
    cfg_i.y_width    <= 3'(yw);
    cfg_i.y_height   <= 4'(yh);
    cfg_i.z_width    <= 3'(zw);
    cfg_i.z_height   <= 4'(zh);
    cfg_i.first_load <= 1'b0;
    cfg_i.z_base     <= base;
    cfg_i.z_stride   <= stride;
    @(negedge clk_i);
  endtask

  // Sends n random beats; loaded must stay low until the last one transfers
  task automatic load_tile(input int n);
    for (int c = 0; c < n; c++) begin
      for (int d = 0; d < BD; d++) begin
        sent_beat[c][d*W +: W] = next_word();
      end
      @(posedge clk_i);
      mem_rvalid_i <= 1'b1;
      mem_rdata_i  <= sent_beat[c];
      do begin
        @(negedge clk_i);
        checks++;
        assert (!loaded_o) else begin
          errors++;
          $display("Error at %0t ns: loaded raised before the last load beat", $time);
        end
      end while (!mem_rready_o);
    end
    @(posedge clk_i);
    mem_rvalid_i <= 1'b0;
  endtask

  task automatic wait_loaded();
    do @(negedge clk_i); while (!loaded_o);
  endtask

  // Row d of the array is word d of every loaded beat
  task automatic push_tile(input int w, input int h);
    for (int d = 0; d < h; d++) begin
      @(posedge clk_i);
      y_push_i <= 1'b1;
      @(negedge clk_i);
      for (int c = 0; c < w; c++) begin
        check_value(y_row_o[c], sent_beat[c][d*W +: W], "pushed word");
      end
      check_value(y_pushed_o, (d == h - 1), "y_pushed flag");
    end
    @(posedge clk_i);
    y_push_i <= 1'b0;
  endtask

  task automatic fill_tile();
    logic [AW-1:0][W-1:0] rows [BD];
    store_beat_t          beat;
    logic [DW-1:0]        strb;
    int                   h;
    h = cfg_i.z_height;
    for (int r = 0; r < h; r++) begin
      for (int c = 0; c < AW; c++) begin
        rows[r][c] = next_word();
      end
    end
    strb = lane_mask(h, W / 8);
    for (int c = 0; c < cfg_i.z_width; c++) begin
      beat.data = '0;
      for (int r = 0; r < h; r++) begin
        beat.data[r*W +: W] = rows[r][c];
      end
      beat.strb = strb[DW/8-1:0];
      exp_beat_q.push_back(beat);
      exp_addr_q.push_back(cfg_i.z_base + 32'(c) * cfg_i.z_stride);
    end
    for (int r = 0; r < h; r++) begin
      @(posedge clk_i);
      fill_i  <= 1'b1;
      z_row_i <= rows[r];
    end
    @(posedge clk_i);
    fill_i <= 1'b0;
  endtask

  task automatic wait_stores();
    while (exp_beat_q.size() != 0) @(negedge clk_i);
    @(posedge clk_i);
  endtask

  task automatic test_load_push();
    set_cfg(3, 6, 1, 1, 32'h0, 32'h0);
    load_tile(3);
    wait_loaded();
    push_tile(3, 6);
    @(negedge clk_i);
    check_value(loaded_o, 1'b0, "loaded flag after pushes");
  endtask

  task automatic test_fill_store();
    int start;
    start = writes;
    set_cfg(1, 1, 4, 5, 32'h1000, 32'h40);
    fill_tile();
    wait_stores();
    check_value(writes - start, 4, "write beat count");
  endtask

  task automatic test_backpressure();
    int start;
    start = writes;
    set_cfg(1, 1, 4, 8, 32'h2000, 32'h100);
    fill_tile();
    while (writes < start + 1) @(posedge clk_i);
    mem_wready_i <= 1'b0;
    repeat (5) @(posedge clk_i);
    mem_wready_i <= 1'b1;
    wait_stores();
    check_value(writes - start, 4, "write beat count under stall");
  endtask

  task automatic test_height_one();
    int start;
    start = writes;
    set_cfg(1, 1, 2, 1, 32'h3000, 32'h10);
    fill_tile();
    wait_stores();
    check_value(writes - start, 2, "write beat count of height one");
  endtask

  task automatic test_clear_load();
    set_cfg(4, 4, 1, 1, 32'h0, 32'h0);
    load_tile(2);
    @(posedge clk_i);
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i <= 1'b0;
    @(negedge clk_i);
    check_value(loaded_o, 1'b0, "loaded flag after clear");
    load_tile(4);
    wait_loaded();
    push_tile(4, 4);
  endtask

  // Write side monitor, sampled mid-cycle
  always @(negedge clk_i) begin
    if (rst_ni && stalled) begin
      check_value(mem_waddr_o, held_addr, "held write address");
      check_value(mem_wdata_o, held_beat.data, "held write data");
      check_value(mem_wstrb_o, held_beat.strb, "held write strobe");
    end
    stalled   = mem_wvalid_o && !mem_wready_i;
    held_addr = mem_waddr_o;
    held_beat = '{data: mem_wdata_o, strb: mem_wstrb_o};
    if (rst_ni && mem_wvalid_o && mem_wready_i) begin
      checks++;
      assert (exp_beat_q.size() != 0) else begin
        errors++;
        $display("Error at %0t ns: write beat with no column left to store", $time);
      end
      if (exp_beat_q.size() != 0) begin
        exp_beat  = exp_beat_q.pop_front();
        exp_addr  = exp_addr_q.pop_front();
        data_mask = lane_mask(cfg_i.z_height, W);
        check_value(mem_wdata_o & data_mask, exp_beat.data, "write data");
        check_value(mem_wstrb_o, exp_beat.strb, "write strobe");
        check_value(mem_waddr_o, exp_addr, "write address");
        writes++;
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Error: run stopped after %0d cycles without finishing", cycles);
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    errors       = 0;
    checks       = 0;
    writes       = 0;
    stalled      = 1'b0;
    lcg_state    = 32'd30;
    rst_ni       = 1'b0;
    clear_i      = 1'b0;
    cfg_i        = '0;
    fill_i       = 1'b0;
    z_row_i      = '0;
    y_push_i     = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = '0;
    mem_wready_i = 1'b1;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_value(mem_wvalid_o, 1'b0, "write valid after reset");
    check_value(loaded_o, 1'b0, "loaded flag after reset");
    check_value(empty_o, 1'b0, "empty flag after reset");
    check_value(mem_rready_o, 1'b1, "read ready after reset");
    test_load_push();
    test_fill_store();
    test_backpressure();
    test_height_one();
    test_clear_load();
    repeat (2) @(posedge clk_i);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule : tb_zbuf_top

// ==== verif/zbuf_chk.sv ====
// ******************************
// Z buffer checker
// Write hold, reset and flag rules
// ******************************

`timescale 1ns/1ps
`include "zbuf_macros.svh"

module zbuf_chk
  import zbuf_pkg::*;
(
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      clear_i,
  input tile_cfg_t                 cfg_i,
  input logic                      mem_wvalid_o,
  input logic                      mem_wready_i,
  input logic [`ZBUF_ADDR_W-1:0]   mem_waddr_o,
  input logic [`ZBUF_MEM_DW-1:0]   mem_wdata_o,
  input logic [`ZBUF_MEM_DW/8-1:0] mem_wstrb_o,
  input logic                      loaded_o,
  input logic                      empty_o,
  input logic                      y_pushed_o
);

  // A stalled write keeps its beat until accepted
  write_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_wvalid_o && !mem_wready_i && !clear_i) |=> (mem_wvalid_o &&
      $stable(mem_waddr_o) && $stable(mem_wdata_o) && $stable(mem_wstrb_o)))
    else $error("write beat changed or dropped while stalled");

  no_write_at_reset: assert property (@(posedge clk_i)
    (!rst_ni || $rose(rst_ni)) |-> !mem_wvalid_o)
    else $error("write valid high during or right after reset");

  // Only a first-load tile may flag empty on its last push
  push_flags: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (y_pushed_o && !cfg_i.first_load) |-> !(loaded_o && empty_o))
    else $error("loaded and empty high together on a push");

endmodule : zbuf_chk

bind zbuf_top zbuf_chk i_chk (
  .clk_i        ( clk_i        ),
  .rst_ni       ( rst_ni       ),
  .clear_i      ( clear_i      ),
  .cfg_i        ( cfg_i        ),
  .mem_wvalid_o ( mem_wvalid_o ),
  .mem_wready_i ( mem_wready_i ),
  .mem_waddr_o  ( mem_waddr_o  ),
  .mem_wdata_o  ( mem_wdata_o  ),
  .mem_wstrb_o  ( mem_wstrb_o  ),
  .loaded_o     ( loaded_o     ),
  .empty_o      ( empty_o      ),
  .y_pushed_o   ( y_pushed_o   )
);
